// ==== pcie_axil_defs.svh ====
// pcie axi-lite master widths, cq header field positions and axi protection value
`ifndef PCIE_AXIL_DEFS_SVH
`define PCIE_AXIL_DEFS_SVH

// stream widths of the 128-bit core interface
`define PCIE_DATA_W 128
`define PCIE_KEEP_W 4
`define CQ_USER_W   88
`define CC_USER_W   33

`define AXIL_ADDR_W 16 // at least 7 for the lower address field

// low bits of the cq descriptor fields
`define CQ_ADDR_LO  2
`define CQ_DWCNT_LO 64
`define CQ_TYPE_LO  75
`define CQ_REQID_LO 80
`define CQ_TAG_LO   96
`define CQ_TC_LO    121
`define CQ_ATTR_LO  124

`define AXIL_PROT 3'b010 // unprivileged, non-secure, data

`endif

// ==== pcie_axil_pkg.sv ====
// shared types of the pcie axi-lite master
`include "pcie_axil_defs.svh"

package pcie_axil_pkg;

    typedef logic [31:0]             dword_t;
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [3:0]              be_t;
    typedef logic [15:0]             req_id_t;
    typedef logic [7:0]              tag_t;
    typedef logic [2:0]              tc_t;
    typedef logic [2:0]              attr_t;
    typedef logic [`PCIE_DATA_W-1:0] pcie_data_t;
    typedef logic [`PCIE_KEEP_W-1:0] pcie_keep_t;
    typedef logic [`CC_USER_W-1:0]   cc_user_t;

    // request type field of the cq descriptor
    typedef enum logic [3:0] {
        req_mem_read        = 4'b0000,
        req_mem_write       = 4'b0001,
        req_io_read         = 4'b0010,
        req_io_write        = 4'b0011,
        req_mem_fetch_add   = 4'b0100,
        req_mem_swap        = 4'b0101,
        req_mem_cas         = 4'b0110,
        req_mem_read_locked = 4'b0111,
        req_cfg_read_0      = 4'b1000,
        req_cfg_read_1      = 4'b1001,
        req_cfg_write_0     = 4'b1010,
        req_cfg_write_1     = 4'b1011,
        req_msg             = 4'b1100,
        req_msg_vendor      = 4'b1101,
        req_msg_ats         = 4'b1110
    } req_type_e;

    typedef enum logic [2:0] {
        status_sc = 3'b000,
        status_ur = 3'b001,
        status_ca = 3'b100
    } cpl_status_e;

    typedef enum logic [1:0] {axi_read, axi_write, cpl_only} desc_op_e;

    typedef enum logic [1:0] {dec_idle, dec_write_data, dec_wait_end} decode_state_e;
    typedef enum logic [1:0] {acc_idle, acc_read, acc_write, acc_cpl} access_state_e;

endpackage

// ==== cq_req_decode.sv ====
// cq request decoder, turns cq packets into access descriptors and flags errors
`include "pcie_axil_defs.svh"

module cq_req_decode import pcie_axil_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  pcie_data_t            cq_tdata,
    input  logic [`CQ_USER_W-1:0] cq_tuser,
    input  logic                  cq_tlast,
    input  logic                  cq_tvalid,
    output logic                  cq_tready,
    output logic                  desc_valid,
    input  logic                  desc_ready,
    output desc_op_e              desc_op,
    output logic                  desc_posted,
    output axil_addr_t            desc_addr,
    output dword_t                desc_wdata,
    output be_t                   desc_strb,
    output cpl_status_e           desc_status,
    output req_id_t               desc_requester_id,
    output tag_t                  desc_tag,
    output tc_t                   desc_tc,
    output attr_t                 desc_attr,
    output logic                  stat_err_cor,
    output logic                  stat_err_uncor
);

    decode_state_e state;
    req_type_e     hdr_type;
    logic [10:0]   hdr_dw_count;
    logic          cq_fire;
    logic          drop; // packet ends without a descriptor

    // classification of the header beat on the bus
    desc_op_e      hdr_op;
    cpl_status_e   hdr_status;
    logic          hdr_write_data;
    logic          hdr_drop;
    logic          hdr_cor;
    logic          hdr_uncor;

    assign hdr_type     = req_type_e'(cq_tdata[`CQ_TYPE_LO +: 4]);
    assign hdr_dw_count = cq_tdata[`CQ_DWCNT_LO +: 11];
    assign cq_fire      = cq_tvalid && cq_tready;

    always_comb begin
        hdr_op         = cpl_only;
        hdr_status     = status_sc;
        hdr_write_data = 1'b0;
        hdr_drop       = 1'b0;
        hdr_cor        = 1'b0;
        hdr_uncor      = 1'b0;
        if (hdr_type == req_mem_read || hdr_type == req_io_read) begin
            if (cq_tlast && hdr_dw_count == 11'd1) begin
                hdr_op = axi_read;
            end else begin
                hdr_status = status_ca; // bad length
                hdr_cor    = 1'b1;
            end
        end else if (hdr_type == req_mem_write || hdr_type == req_io_write) begin
            if (!cq_tlast && hdr_dw_count == 11'd1) begin
                hdr_op         = axi_write;
                hdr_write_data = 1'b1; // data dword on the next beat
            end else if (hdr_type == req_mem_write) begin
                hdr_drop  = 1'b1; // posted, no completion possible
                hdr_uncor = 1'b1;
            end else begin
                hdr_status = status_ca;
                hdr_cor    = 1'b1;
            end
        end else if (hdr_type[3:2] == 2'b11) begin
            hdr_drop  = 1'b1; // messages
            hdr_uncor = 1'b1;
        end else begin
            hdr_status = status_ur; // atomics, config, locked reads
            hdr_cor    = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        stat_err_cor   <= 1'b0;
        stat_err_uncor <= 1'b0;
        cq_tready      <= (state == dec_idle) && !desc_valid;
        if (desc_ready) begin
            desc_valid <= 1'b0;
        end

        case (state)
            dec_idle: begin
                if (cq_fire) begin
                    desc_addr         <= {cq_tdata[`AXIL_ADDR_W-1:`CQ_ADDR_LO], 2'b00};
                    desc_strb         <= cq_tuser[3:0]; // first byte enables
                    desc_requester_id <= cq_tdata[`CQ_REQID_LO +: 16];
                    desc_tag          <= cq_tdata[`CQ_TAG_LO +: 8];
                    desc_tc           <= cq_tdata[`CQ_TC_LO +: 3];
                    desc_attr         <= cq_tdata[`CQ_ATTR_LO +: 3];
                    desc_op           <= hdr_op;
                    desc_status       <= hdr_status;
                    desc_posted       <= (hdr_type == req_mem_write);
                    drop              <= hdr_drop;
                    stat_err_cor      <= hdr_cor;
                    stat_err_uncor    <= hdr_uncor;
                    if (hdr_write_data) begin
                        state     <= dec_write_data;
                        cq_tready <= 1'b1;
                    end else if (!cq_tlast) begin
                        state     <= dec_wait_end;
                        cq_tready <= 1'b1;
                    end else if (!hdr_drop) begin
                        desc_valid <= 1'b1;
                        cq_tready  <= 1'b0; // hold off until the slot drains
                    end else begin
                        cq_tready <= 1'b0; // gap after a drop keeps error pulses apart
                    end
                end
            end
            dec_write_data: begin
                cq_tready <= !(cq_fire && cq_tlast);
                if (cq_fire) begin
                    desc_wdata <= cq_tdata[31:0];
                    if (cq_tlast) begin
                        desc_valid <= 1'b1;
                        state      <= dec_idle;
                    end else begin
                        // payload longer than the header claimed
                        desc_op     <= cpl_only;
                        desc_status <= status_ca;
                        drop        <= desc_posted;
                        state       <= dec_wait_end;
                    end
                end
            end
            dec_wait_end: begin
                cq_tready <= !(cq_fire && cq_tlast);
                if (cq_fire && cq_tlast) begin
                    desc_valid <= !drop;
                    state      <= dec_idle;
                end
            end
            default: state <= dec_idle;
        endcase

        if (rst) begin
            state          <= dec_idle;
            cq_tready      <= 1'b0;
            desc_valid     <= 1'b0;
            stat_err_cor   <= 1'b0;
            stat_err_uncor <= 1'b0;
        end
    end

endmodule

// ==== axil_access.sv ====
// axi-lite access stage, runs one read or write per descriptor and passes on completion work
`include "pcie_axil_defs.svh"

module axil_access import pcie_axil_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        desc_valid,
    output logic        desc_ready,
    input  desc_op_e    desc_op,
    input  logic        desc_posted,
    input  axil_addr_t  desc_addr,
    input  dword_t      desc_wdata,
    input  be_t         desc_strb,
    input  cpl_status_e desc_status,
    input  req_id_t     desc_requester_id,
    input  tag_t        desc_tag,
    input  tc_t         desc_tc,
    input  attr_t       desc_attr,
    output axil_addr_t  awaddr,
    output logic [2:0]  awprot,
    output logic        awvalid,
    input  logic        awready,
    output dword_t      wdata,
    output be_t         wstrb,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    output axil_addr_t  araddr,
    output logic [2:0]  arprot,
    output logic        arvalid,
    input  logic        arready,
    input  dword_t      rdata,
    input  logic        rvalid,
    output logic        rready,
    output logic        cpl_valid,
    input  logic        cpl_ready,
    output logic        cpl_has_data,
    output dword_t      cpl_rdata,
    output cpl_status_e cpl_status,
    output logic [4:0]  cpl_addr_lo,
    output be_t         cpl_first_be,
    output req_id_t     cpl_requester_id,
    output tag_t        cpl_tag,
    output tc_t         cpl_tc,
    output attr_t       cpl_attr
);

    access_state_e state;
    axil_addr_t    addr;
    logic          posted; // memory write, retired on the response

    assign desc_ready  = (state == acc_idle);
    assign cpl_valid   = (state == acc_cpl);
    assign awaddr      = addr;
    assign araddr      = addr;
    assign awprot      = `AXIL_PROT;
    assign arprot      = `AXIL_PROT;
    assign wstrb       = cpl_first_be;
    assign cpl_addr_lo = addr[6:2];

    // responses only taken while the formatter has room
    assign rready = (state == acc_read) && cpl_ready;
    assign bready = (state == acc_write) && cpl_ready;

    always_ff @(posedge clk) begin
        case (state)
            acc_idle: begin
                if (desc_valid) begin
                    addr             <= desc_addr;
                    wdata            <= desc_wdata;
                    posted           <= desc_posted;
                    cpl_first_be     <= desc_strb;
                    cpl_status       <= desc_status;
                    cpl_requester_id <= desc_requester_id;
                    cpl_tag          <= desc_tag;
                    cpl_tc           <= desc_tc;
                    cpl_attr         <= desc_attr;
                    cpl_has_data     <= (desc_op == axi_read);
                    case (desc_op)
                        axi_read: begin
                            arvalid <= 1'b1;
                            state   <= acc_read;
                        end
                        axi_write: begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= acc_write;
                        end
                        default: state <= acc_cpl; // status only
                    endcase
                end
            end
            acc_read: begin
                if (arready) begin
                    arvalid <= 1'b0;
                end
                if (rvalid && rready) begin
                    cpl_rdata <= rdata;
                    state     <= acc_cpl;
                end
            end
            acc_write: begin
                if (awready) begin
                    awvalid <= 1'b0;
                end
                if (wready) begin
                    wvalid <= 1'b0;
                end
                if (bvalid && bready) begin
                    state <= posted ? acc_idle : acc_cpl;
                end
            end
            acc_cpl: begin
                if (cpl_ready) begin
                    state <= acc_idle;
                end
            end
        endcase

        if (rst) begin
            state   <= acc_idle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
    end

endmodule

// ==== cpl_format.sv ====
// completion formatter, holds one completion and builds its 128-bit cc beat
module cpl_format import pcie_axil_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpl_valid,
    output logic        cpl_ready,
    input  logic        cpl_has_data,
    input  dword_t      cpl_rdata,
    input  cpl_status_e cpl_status,
    input  logic [4:0]  cpl_addr_lo,
    input  be_t         cpl_first_be,
    input  req_id_t     cpl_requester_id,
    input  tag_t        cpl_tag,
    input  tc_t         cpl_tc,
    input  attr_t       cpl_attr,
    input  req_id_t     completer_id,
    input  logic        completer_id_en,
    output pcie_data_t  beat_data,
    output pcie_keep_t  beat_keep,
    output cc_user_t    beat_user,
    output logic        beat_valid,
    input  logic        beat_ready
);

    logic        has_data;
    dword_t      rdata;
    cpl_status_e status;
    logic [4:0]  addr_lo;
    be_t         first_be;
    req_id_t     requester_id;
    tag_t        tag;
    tc_t         tc;
    attr_t       attr;

    logic [1:0]  be_lo; // lowest enabled byte
    logic [1:0]  be_hi;
    logic [12:0] byte_count;
    logic [95:0] cpl_hdr;

    always_comb begin
        be_lo = 2'd0;
        be_hi = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (first_be[i]) be_lo = 2'(i);
        end
        for (int i = 0; i < 4; i++) begin
            if (first_be[i]) be_hi = 2'(i);
        end
        if (first_be == 4'b0000) begin
            byte_count = 13'd1; // zero-length read still reports one byte
        end else begin
            byte_count = 13'(be_hi - be_lo) + 13'd1;
        end
    end

    // completion descriptor, dwords 0 to 2
    assign cpl_hdr = {1'b0, attr, tc, completer_id_en, completer_id, tag, requester_id,
                      2'b00, status, 11'(has_data), 3'b000, byte_count,
                      9'd0, addr_lo, be_lo};

    assign cpl_ready = !beat_valid || beat_ready;
    assign beat_data = {rdata, cpl_hdr};
    assign beat_keep = {has_data, 3'b111};
    assign beat_user = '0; // no discontinue, no parity

    always_ff @(posedge clk) begin
        if (beat_ready) begin
            beat_valid <= 1'b0;
        end
        if (cpl_valid && cpl_ready) begin
            beat_valid   <= 1'b1;
            has_data     <= cpl_has_data;
            rdata        <= cpl_rdata;
            status       <= cpl_status;
            addr_lo      <= cpl_addr_lo;
            first_be     <= cpl_first_be;
            requester_id <= cpl_requester_id;
            tag          <= cpl_tag;
            tc           <= cpl_tc;
            attr         <= cpl_attr;
        end
        if (rst) begin
            beat_valid <= 1'b0;
        end
    end

endmodule

// ==== cc_skid_buffer.sv ====
// cc output register with a second entry, so cc_tready never reaches the pipeline
module cc_skid_buffer import pcie_axil_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pcie_data_t beat_data,
    input  pcie_keep_t beat_keep,
    input  cc_user_t   beat_user,
    input  logic       beat_valid,
    output logic       beat_ready,
    output pcie_data_t cc_tdata,
    output pcie_keep_t cc_tkeep,
    output cc_user_t   cc_tuser,
    output logic       cc_tvalid,
    output logic       cc_tlast,
    input  logic       cc_tready
);

    pcie_data_t tmp_data;
    pcie_keep_t tmp_keep;
    cc_user_t   tmp_user;
    logic       tmp_valid;
    logic       in_fire;

    assign beat_ready = !tmp_valid; // room while the second entry is free
    assign in_fire    = beat_valid && beat_ready;
    assign cc_tlast   = 1'b1;       // every completion is one beat

    always_ff @(posedge clk) begin
        if (!cc_tvalid || cc_tready) begin
            if (tmp_valid) begin
                cc_tdata  <= tmp_data; // refill from the second entry
                cc_tkeep  <= tmp_keep;
                cc_tuser  <= tmp_user;
                cc_tvalid <= 1'b1;
                tmp_valid <= 1'b0;
            end else begin
                cc_tvalid <= in_fire;
                if (in_fire) begin
                    cc_tdata <= beat_data;
                    cc_tkeep <= beat_keep;
                    cc_tuser <= beat_user;
                end
            end
        end else if (in_fire) begin
            tmp_data  <= beat_data;
            tmp_keep  <= beat_keep;
            tmp_user  <= beat_user;
            tmp_valid <= 1'b1;
        end

        if (rst) begin
            cc_tvalid <= 1'b0;
            tmp_valid <= 1'b0;
        end
    end

endmodule

// ==== pcie_axil_master.sv ====
// pcie completer to axi-lite master bridge, decode, access, format and cc register stages
`include "pcie_axil_defs.svh"

module pcie_axil_master import pcie_axil_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  pcie_data_t            cq_tdata,
    input  logic [`CQ_USER_W-1:0] cq_tuser,
    input  logic                  cq_tlast,
    input  logic                  cq_tvalid,
    output logic                  cq_tready,
    output pcie_data_t            cc_tdata,
    output pcie_keep_t            cc_tkeep,
    output logic                  cc_tlast,
    output cc_user_t              cc_tuser,
    output logic                  cc_tvalid,
    input  logic                  cc_tready,
    output axil_addr_t            awaddr,
    output logic [2:0]            awprot,
    output logic                  awvalid,
    input  logic                  awready,
    output dword_t                wdata,
    output be_t                   wstrb,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    output axil_addr_t            araddr,
    output logic [2:0]            arprot,
    output logic                  arvalid,
    input  logic                  arready,
    input  dword_t                rdata,
    input  logic                  rvalid,
    output logic                  rready,
    input  req_id_t               completer_id,
    input  logic                  completer_id_en,
    output logic                  stat_err_cor,
    output logic                  stat_err_uncor
);

    // descriptor link
    logic        desc_valid;
    logic        desc_ready;
    desc_op_e    desc_op;
    logic        desc_posted;
    axil_addr_t  desc_addr;
    dword_t      desc_wdata;
    be_t         desc_strb;
    cpl_status_e desc_status;
    req_id_t     desc_requester_id;
    tag_t        desc_tag;
    tc_t         desc_tc;
    attr_t       desc_attr;

    // completion link
    logic        cpl_valid;
    logic        cpl_ready;
    logic        cpl_has_data;
    dword_t      cpl_rdata;
    cpl_status_e cpl_status;
    logic [4:0]  cpl_addr_lo;
    be_t         cpl_first_be;
    req_id_t     cpl_requester_id;
    tag_t        cpl_tag;
    tc_t         cpl_tc;
    attr_t       cpl_attr;

    // beat link
    pcie_data_t  beat_data;
    pcie_keep_t  beat_keep;
    cc_user_t    beat_user;
    logic        beat_valid;
    logic        beat_ready;

    cq_req_decode  u_decode (.*);
    axil_access    u_access (.*);
    cpl_format     u_format (.*);
    cc_skid_buffer u_skid   (.*);

endmodule

// ==== pcie_axil_chk.sv ====
// stream and axi-lite handshake assertions for the pcie axi-lite master
module pcie_axil_chk (
    input logic clk,
    input logic rst,
    input logic cc_tvalid,
    input logic cc_tready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready,
    input logic stat_err_cor,
    input logic stat_err_uncor
);

    // a valid holds until its ready
    a_cc_hold: assert property (@(posedge clk) disable iff (rst)
        cc_tvalid && !cc_tready |=> cc_tvalid) else $error("cc_tvalid dropped before cc_tready");
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");

    // error flags are single-cycle pulses
    a_cor_pulse: assert property (@(posedge clk) disable iff (rst)
        stat_err_cor |=> !stat_err_cor) else $error("stat_err_cor high two cycles");
    a_uncor_pulse: assert property (@(posedge clk) disable iff (rst)
        stat_err_uncor |=> !stat_err_uncor) else $error("stat_err_uncor high two cycles");

endmodule

bind pcie_axil_master pcie_axil_chk u_chk (.*);

// ==== tb_pcie_axil_master.sv ====
// testbench for the pcie axi-lite master, random cq requests against a completion model
`include "pcie_axil_defs.svh"

module tb_pcie_axil_master import pcie_axil_pkg::*; ();

    localparam int NUM_PKTS   = 63; // packets over all tests
    localparam int WATCHDOG_T = NUM_PKTS * 200 * 20;

    typedef struct packed {
        logic        has_data;
        logic [2:0]  status;
        logic [31:0] data;
        logic [12:0] byte_count;
        logic [6:0]  lower_addr;
        req_id_t     req_id;
        tag_t        tag;
        tc_t         tc;
        attr_t       attr;
    } cpl_exp_t;

    logic clk = 1'b0;
    logic rst;
    pcie_data_t cq_tdata;
    logic [`CQ_USER_W-1:0] cq_tuser;
    logic cq_tlast, cq_tvalid, cq_tready;
    pcie_data_t cc_tdata;
    pcie_keep_t cc_tkeep;
    cc_user_t cc_tuser;
    logic cc_tlast, cc_tvalid, cc_tready;
    axil_addr_t awaddr, araddr;
    logic [2:0] awprot, arprot;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    dword_t wdata, rdata;
    be_t wstrb;
    req_id_t completer_id;
    logic completer_id_en;
    logic stat_err_cor, stat_err_uncor;

    logic [31:0] lfsr_state = 32'ha632_9034;
    dword_t      mem [64];       // slave memory
    dword_t      model_mem [64]; // expected contents
    cpl_exp_t    exp_q [$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cor_seen = 0;
    int          uncor_seen = 0;
    int          cor_exp = 0;
    int          uncor_exp = 0;

    pcie_axil_master uut (.*);

    always #10 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic dword_t fill_word(input int i);
        return (32'h9e37_79b9 * (i + 1)) ^ {i[7:0], ~i[7:0], i[7:0], 8'h3c};
    endfunction

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // one cq beat, called and returning on a falling edge
    task automatic send_beat(input pcie_data_t data, input be_t be, input logic last);
        cq_tdata  = data;
        cq_tuser  = {{(`CQ_USER_W-4){1'b0}}, be};
        cq_tlast  = last;
        cq_tvalid = 1'b1;
        while (!cq_tready) @(negedge clk);
        @(negedge clk);
        cq_tvalid = 1'b0;
    endtask

    task automatic send_req(input req_type_e rtype, input logic [10:0] dw_count,
                            input logic [15:0] addr, input be_t be, input dword_t data);
        pcie_data_t hdr;
        cpl_exp_t   e;
        int         idx;
        int         lo;
        int         hi;
        logic       is_write;
        logic       is_read;
        idx      = addr[7:2];
        is_write = (rtype == req_mem_write) || (rtype == req_io_write);
        is_read  = (rtype == req_mem_read) || (rtype == req_io_read);
        hdr      = '0;
        e        = '0;
        hdr[15:2]                   = addr[15:2];
        hdr[`CQ_DWCNT_LO +: 11]     = dw_count;
        hdr[`CQ_TYPE_LO +: 4]       = rtype;
        hdr[`CQ_REQID_LO +: 16]     = rand_bits(16);
        hdr[`CQ_TAG_LO +: 8]        = rand_bits(8);
        hdr[`CQ_TC_LO +: 3]         = rand_bits(3);
        hdr[`CQ_ATTR_LO +: 3]       = rand_bits(3);
        e.req_id = hdr[`CQ_REQID_LO +: 16];
        e.tag    = hdr[`CQ_TAG_LO +: 8];
        e.tc     = hdr[`CQ_TC_LO +: 3];
        e.attr   = hdr[`CQ_ATTR_LO +: 3];
        // byte count spans first to last enabled byte
        lo = 0;
        hi = 0;
        for (int b = 3; b >= 0; b--) if (be[b]) lo = b;
        for (int b = 0; b < 4; b++) if (be[b]) hi = b;
        e.byte_count = (be == 4'b0000) ? 13'd1 : 13'(hi - lo + 1);
        e.lower_addr = {addr[6:2], 2'(lo)};

        if (is_read && dw_count == 11'd1) begin
            e.has_data = 1'b1;
            e.status   = status_sc;
            e.data     = model_mem[idx];
            exp_q.push_back(e);
        end else if (is_write) begin
            for (int b = 0; b < 4; b++) if (be[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
            if (rtype == req_io_write) begin
                e.status = status_sc;
                exp_q.push_back(e);
            end
        end else if (is_read) begin
            e.status = status_ca; // bad length
            cor_exp++;
            exp_q.push_back(e);
        end else if (rtype[3:2] == 2'b11) begin
            uncor_exp++;          // message, dropped
        end else begin
            e.status = status_ur;
            cor_exp++;
            exp_q.push_back(e);
        end

        send_beat(hdr, be, !is_write);
        if (is_write) send_beat({96'd0, data}, 4'b0000, 1'b1);
    endtask

    task automatic finish_test(input string name, input int err_before);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);
        check("correctable error pulses", cor_seen, cor_exp);
        check("uncorrectable error pulses", uncor_seen, uncor_exp);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    // axi-lite write slave
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && awvalid && wvalid) begin
                repeat (rand_bits(2)) @(negedge clk);
                awready = 1'b1;
                wready  = 1'b1;
                check("awprot", awprot, `AXIL_PROT);
                for (int b = 0; b < 4; b++) if (wstrb[b]) mem[awaddr[7:2]][8*b +: 8] = wdata[8*b +: 8];
                @(negedge clk);
                awready = 1'b0;
                wready  = 1'b0;
                repeat (rand_bits(2)) @(negedge clk);
                bvalid = 1'b1;
                while (!bready) @(negedge clk);
                @(negedge clk);
                bvalid = 1'b0;
            end
        end
    end

    // axi-lite read slave
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                repeat (rand_bits(2)) @(negedge clk);
                arready = 1'b1;
                check("arprot", arprot, `AXIL_PROT);
                rdata   = mem[araddr[7:2]];
                @(negedge clk);
                arready = 1'b0;
                repeat (rand_bits(2)) @(negedge clk);
                rvalid = 1'b1;
                while (!rready) @(negedge clk);
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

    // cc sink with random ready, compares each beat taken
    initial begin
        cpl_exp_t e;
        cc_tready = 1'b0;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            cc_tready = (rand_bits(2) != 2'd0);
            if (stat_err_cor) cor_seen++;
            if (stat_err_uncor) uncor_seen++;
            if (cc_tvalid && cc_tready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected completion on cc at %0t, none was predicted", $time);
                end else begin
                    e = exp_q.pop_front();
                    check("lower address", cc_tdata[6:0], e.lower_addr);
                    check("byte count", cc_tdata[28:16], e.byte_count);
                    check("dword count", cc_tdata[42:32], e.has_data);
                    check("status", cc_tdata[45:43], e.status);
                    check("requester id", cc_tdata[63:48], e.req_id);
                    check("tag", cc_tdata[71:64], e.tag);
                    check("completer id", cc_tdata[87:72], completer_id);
                    check("completer id enable", cc_tdata[88], completer_id_en);
                    check("traffic class", cc_tdata[91:89], e.tc);
                    check("attributes", cc_tdata[94:92], e.attr);
                    check("reserved header bits",
                          {cc_tdata[95], cc_tdata[47:46], cc_tdata[31:29], cc_tdata[15:7]}, '0);
                    check("keep", cc_tkeep, {e.has_data, 3'b111});
                    check("tlast", cc_tlast, 1'b1);
                    check("user", cc_tuser, '0);
                    if (e.has_data) check("data", cc_tdata[127:96], e.data);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int err0;
        logic [15:0] a;
        logic [2:0] pick;
        rst       = 1'b1;
        cq_tdata  = '0;
        cq_tuser  = '0;
        cq_tlast  = 1'b0;
        cq_tvalid = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i]       = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        completer_id    = rand_bits(16);
        completer_id_en = rand_bits(1);
        repeat (8) @(negedge clk);
        rst = 1'b0;

        err0 = errors;
        for (int k = 0; k < 8; k++) begin
            a = {8'(rand_bits(8)), 6'(rand_bits(6)), 2'b00};
            send_req(req_mem_write, 11'd1, a, rand_bits(4), rand_bits(32));
            send_req(req_mem_read, 11'd1, a, rand_bits(4), '0);
        end
        finish_test("write_then_read", err0);

        err0 = errors;
        send_req(req_io_write, 11'd1, 16'h0040, 4'b0110, rand_bits(32));
        send_req(req_mem_write, 11'd1, 16'h0044, 4'b1111, rand_bits(32));
        finish_test("io_and_mem_write", err0);

        err0 = errors;
        for (int k = 0; k < 3; k++) begin
            send_req(req_mem_read, 11'd2 + rand_bits(3), 16'(rand_bits(6)) << 2, rand_bits(4), '0);
        end
        finish_test("bad_length_read", err0);

        err0 = errors;
        send_req(req_cfg_read_0, 11'd1, 16'h0010, 4'b1111, '0);
        send_req(req_msg, 11'd0, 16'h0000, 4'b0000, '0);
        finish_test("config_and_message", err0);

        err0 = errors;
        for (int k = 0; k < 40; k++) begin
            a    = {8'(rand_bits(8)), 6'(rand_bits(6)), 2'b00};
            pick = rand_bits(3);
            case (pick)
                3'd0, 3'd1: send_req(req_mem_read, 11'd1, a, rand_bits(4), '0);
                3'd2, 3'd3: send_req(req_mem_write, 11'd1, a, rand_bits(4), rand_bits(32));
                3'd4: send_req(req_io_write, 11'd1, a, rand_bits(4), rand_bits(32));
                3'd5: send_req(req_io_read, 11'd1, a, rand_bits(4), '0);
                3'd6: send_req(req_mem_read, 11'd4, a, rand_bits(4), '0);
                default: begin
                    if (rand_bits(1)) send_req(req_cfg_read_1, 11'd1, a, 4'b1111, '0);
                    else send_req(req_msg_vendor, 11'd0, a, 4'b0000, '0);
                end
            endcase
        end
        finish_test("random_mix", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
pcie_axil_pkg.sv
cq_req_decode.sv
axil_access.sv
cpl_format.sv
cc_skid_buffer.sv
pcie_axil_master.sv
pcie_axil_chk.sv
tb_pcie_axil_master.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator, result taken from the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_axil_master \
    -f project.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log && exit 0 || exit 1
